// File: hdl/uart_pkg.sv
/*
 * uart shared types
 * character, receive word and receiver state definitions used by
 * the transmit path, the receive path and the host ports
 */

`default_nettype none

package uart_pkg;

    // one character on the serial line
    typedef logic [7:0] byte_t;

    // receive word as stored in the rx fifo and seen by the host
    // frame_error set when the stop bit sampled low
    typedef struct packed {
        byte_t data;
        logic  frame_error;
    } rx_word_t;

    // receiver fsm
    // idle   waiting for a falling edge on the line
    // start  re-checking the start bit at half a bit period
    // data   sampling the eight data bits
    // stop   sampling the stop bit
    typedef enum logic [1:0] {
        idle,
        start,
        data,
        stop
    } uart_rx_state_e;

endpackage

`default_nettype wire

// File: hdl/byte_fifo.sv
/*
 * byte_fifo
 * synchronous circular buffer of WIDTH-wide words, 2**FIFO_DEPTH_LOG2
 * deep, with full and empty levels. writes into a full buffer and
 * reads from an empty one are ignored. the head word is always shown
 * on read_data and is valid while empty is low.
 */

`timescale 1ns/1ps
`default_nettype none

module byte_fifo #(
    parameter int WIDTH           = 8,
    parameter int FIFO_DEPTH_LOG2 = 4
) (
    input  wire logic             clk,
    input  wire logic             reset,

    input  wire logic             write,
    input  wire logic [WIDTH-1:0] write_data,

    input  wire logic             read,
    output logic      [WIDTH-1:0] read_data,

    output logic                  full,
    output logic                  empty
);

    localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

    // pointer indexes the store
    // count is one bit wider to hold DEPTH
    typedef logic [FIFO_DEPTH_LOG2-1:0] ptr_t;
    typedef logic [FIFO_DEPTH_LOG2:0]   count_t;

    logic [WIDTH-1:0] mem [0:DEPTH-1];

    ptr_t   write_ptr;
    ptr_t   read_ptr;
    count_t count;

    // qualified requests
    logic do_write;
    logic do_read;

    assign full     = (count == count_t'(DEPTH));
    assign empty    = (count == '0);
    assign do_write = write & ~full;
    assign do_read  = read & ~empty;

    // head of the buffer, straight from the store
    assign read_data = mem[read_ptr];

    // storage
    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[write_ptr] <= write_data;
        end
    end

    // pointers wrap naturally at DEPTH
    always_ff @(posedge clk) begin
        if (reset) begin
            write_ptr <= '0;
            read_ptr  <= '0;
            count     <= '0;
        end else begin
            if (do_write) begin
                write_ptr <= write_ptr + ptr_t'(1);
            end
            if (do_read) begin
                read_ptr <= read_ptr + ptr_t'(1);
            end
            // occupancy unchanged when both happen together
            case ({do_write, do_read})
                2'b10:   count <= count + count_t'(1);
                2'b01:   count <= count - count_t'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/uart_transmitter.sv
/*
 * uart_transmitter
 * takes a byte over valid/ready and sends it as one start bit, eight
 * data bits lsb first and one stop bit. every bit lasts
 * CLOCK_FREQ / BAUD_RATE cycles, and ready only returns once the stop
 * bit has been held for its full period.
 */

`timescale 1ns/1ps
`default_nettype none

module uart_transmitter
    import uart_pkg::*;
#(
    parameter int CLOCK_FREQ = 125_000_000,
    parameter int BAUD_RATE  = 115_200
) (
    input  wire logic  clk,
    input  wire logic  reset,

    input  wire byte_t data,
    input  wire logic  valid,
    output logic       ready,

    output logic       serial_out
);

    localparam int CLKS_PER_BIT    = CLOCK_FREQ / BAUD_RATE;
    localparam int CLK_COUNT_WIDTH = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam int FRAME_BITS      = 10;

    typedef logic [CLK_COUNT_WIDTH-1:0] clk_count_t;
    typedef logic [3:0]                 bit_count_t;
    typedef logic [FRAME_BITS-1:0]      frame_t;

    localparam clk_count_t LAST_CLK = clk_count_t'(CLKS_PER_BIT - 1);

    // bit currently on the line sits in frame_shift[0]
    frame_t     frame_shift;
    // bits of the frame still to send, zero when idle
    bit_count_t bit_count;
    // cycles spent in the current bit
    clk_count_t clk_count;

    always_ff @(posedge clk) begin
        if (reset) begin
            bit_count <= '0;
            clk_count <= '0;
        end else if (valid && ready) begin
            // accept edge
            // stop, data and start bit loaded together
            frame_shift <= {1'b1, data, 1'b0};
            bit_count   <= bit_count_t'(FRAME_BITS);
            clk_count   <= '0;
        end else if (!ready) begin
            if (clk_count == LAST_CLK) begin
                // bit period done, move to the next bit
                clk_count   <= '0;
                bit_count   <= bit_count - bit_count_t'(1);
                frame_shift <= frame_shift >> 1;
            end else begin
                clk_count <= clk_count + clk_count_t'(1);
            end
        end
    end

    // free once the stop bit period is over
    assign ready = (bit_count == '0);

    // line idles high
    assign serial_out = ready ? 1'b1 : frame_shift[0];

endmodule

`default_nettype wire

// File: hdl/uart_receiver.sv
/*
 * uart_receiver
 * synchronizes serial_in, finds the falling edge of a start bit,
 * confirms it at mid-bit and then samples eight data bits and the
 * stop bit one bit period apart. at the stop-bit sample the byte is
 * presented with its framing flag and word_valid pulses for a cycle.
 */

`timescale 1ns/1ps
`default_nettype none

module uart_receiver
    import uart_pkg::*;
#(
    parameter int CLOCK_FREQ = 125_000_000,
    parameter int BAUD_RATE  = 115_200
) (
    input  wire logic clk,
    input  wire logic reset,

    input  wire logic serial_in,

    output logic      word_valid,
    output rx_word_t  word
);

    localparam int CLKS_PER_BIT    = CLOCK_FREQ / BAUD_RATE;
    localparam int HALF_BIT        = CLKS_PER_BIT / 2;
    localparam int CLK_COUNT_WIDTH = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    typedef logic [CLK_COUNT_WIDTH-1:0] clk_count_t;
    typedef logic [2:0]                 bit_index_t;

    // full bit period between samples
    localparam clk_count_t LAST_CLK  = clk_count_t'(CLKS_PER_BIT - 1);
    // synchronizer and edge detect already cost two cycles of the half bit
    localparam clk_count_t START_CLK = clk_count_t'((HALF_BIT > 1) ? HALF_BIT - 2 : 0);

    // two-flop synchronizer, then one more stage for edge detect
    logic serial_meta;
    logic serial_sync;
    logic serial_last;
    logic falling_edge;

    uart_rx_state_e state;
    clk_count_t     clk_count;
    bit_index_t     bit_index;
    // data bits arrive lsb first and shift in from the top
    byte_t          shift_reg;

    // reset high so a quiet line does not look like a start bit
    always_ff @(posedge clk) begin
        if (reset) begin
            serial_meta <= 1'b1;
            serial_sync <= 1'b1;
            serial_last <= 1'b1;
        end else begin
            serial_meta <= serial_in;
            serial_sync <= serial_meta;
            serial_last <= serial_sync;
        end
    end

    assign falling_edge = serial_last & ~serial_sync;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= idle;
            clk_count  <= '0;
            bit_index  <= '0;
            word_valid <= 1'b0;
        end else begin
            // single-cycle pulse by default
            word_valid <= 1'b0;
            case (state)
                idle: begin
                    clk_count <= '0;
                    if (falling_edge) begin
                        state <= start;
                    end
                end
                start: begin
                    if (clk_count == START_CLK) begin
                        clk_count <= '0;
                        bit_index <= '0;
                        // line back high at mid-bit means a glitch
                        state     <= serial_sync ? idle : data;
                    end else begin
                        clk_count <= clk_count + clk_count_t'(1);
                    end
                end
                data: begin
                    if (clk_count == LAST_CLK) begin
                        clk_count <= '0;
                        shift_reg <= {serial_sync, shift_reg[7:1]};
                        if (bit_index == 3'd7) begin
                            state <= stop;
                        end else begin
                            bit_index <= bit_index + bit_index_t'(1);
                        end
                    end else begin
                        clk_count <= clk_count + clk_count_t'(1);
                    end
                end
                stop: begin
                    if (clk_count == LAST_CLK) begin
                        clk_count        <= '0;
                        word.data        <= shift_reg;
                        // a low stop bit is a framing error
                        word.frame_error <= ~serial_sync;
                        word_valid       <= 1'b1;
                        // ready for the next start edge straight away
                        state            <= idle;
                    end else begin
                        clk_count <= clk_count + clk_count_t'(1);
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/uart_top.sv
/*
 * uart_top
 * host-side uart subsystem. host bytes queue in a transmit fifo that
 * feeds the transmitter, and words rebuilt by the receiver queue in a
 * receive fifo that the host pops. baud and fifo depth set here.
 */

`timescale 1ns/1ps
`default_nettype none

module uart_top
    import uart_pkg::*;
#(
    parameter int CLOCK_FREQ      = 125_000_000,
    parameter int BAUD_RATE       = 115_200,
    parameter int FIFO_DEPTH_LOG2 = 4
) (
    input  wire logic  clk,
    input  wire logic  reset,

    // host write side
    input  wire byte_t tx_data,
    input  wire logic  tx_write,
    output logic       tx_full,

    // host read side
    input  wire logic  rx_read,
    output rx_word_t   rx_word,
    output logic       rx_empty,

    // serial line
    output logic       serial_out,
    input  wire logic  serial_in
);

    // transmit path
    byte_t    tx_head;
    logic     tx_empty;
    logic     tx_valid;
    logic     tx_ready;
    logic     tx_pop;

    // receive path
    rx_word_t rx_new_word;
    logic     rx_new_valid;

    // fifo not-empty is valid, transfer pops the head
    assign tx_valid = ~tx_empty;
    assign tx_pop   = tx_valid & tx_ready;

    byte_fifo #(
        .WIDTH           ($bits(byte_t)),
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) i_tx_fifo (
        .clk        (clk),
        .reset      (reset),
        .write      (tx_write),
        .write_data (tx_data),
        .read       (tx_pop),
        .read_data  (tx_head),
        .full       (tx_full),
        .empty      (tx_empty)
    );

    uart_transmitter #(
        .CLOCK_FREQ (CLOCK_FREQ),
        .BAUD_RATE  (BAUD_RATE)
    ) i_uart_transmitter (
        .clk        (clk),
        .reset      (reset),
        .data       (tx_head),
        .valid      (tx_valid),
        .ready      (tx_ready),
        .serial_out (serial_out)
    );

    uart_receiver #(
        .CLOCK_FREQ (CLOCK_FREQ),
        .BAUD_RATE  (BAUD_RATE)
    ) i_uart_receiver (
        .clk        (clk),
        .reset      (reset),
        .serial_in  (serial_in),
        .word_valid (rx_new_valid),
        .word       (rx_new_word)
    );

    // no back-pressure, a word arriving at a full fifo is lost
    byte_fifo #(
        .WIDTH           ($bits(rx_word_t)),
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) i_rx_fifo (
        .clk        (clk),
        .reset      (reset),
        .write      (rx_new_valid),
        .write_data (rx_new_word),
        .read       (rx_read),
        .read_data  (rx_word),
        .full       (),
        .empty      (rx_empty)
    );

endmodule

`default_nettype wire

// File: bench/uart_tb.sv
/*
 * uart_tb
 * testbench for the uart subsystem. drives host writes and reads,
 * loops serial_out back or injects frames on serial_in, decodes the
 * line and checks received words against a reference function.
 */

`timescale 1ns/1ps
`default_nettype none

module uart_tb
    import uart_pkg::*;
();

    localparam int CLOCK_FREQ      = 8_000_000;
    localparam int BAUD_RATE       = 1_000_000;
    localparam int FIFO_DEPTH_LOG2 = 3;
    // frames put on the line plus the write that gets dropped
    localparam int NUM_BYTES       = 15;
    localparam int TIMEOUT_CYCLES  = (NUM_BYTES + 4) * 10 * 8 * 2;
    localparam int DRAIN_CYCLES    = 160;

    logic     clk;
    logic     reset;
    byte_t    tx_data;
    logic     tx_write;
    logic     tx_full;
    logic     rx_read;
    rx_word_t rx_word;
    logic     rx_empty;
    logic     serial_out;
    logic     serial_in;

    // serial_in source select, and the injected line level
    logic loopback;
    logic gen_line;

    // bytes written and accepted, decoded from the line, words due back
    byte_t    sent[$];
    byte_t    decoded[$];
    rx_word_t expected[$];

    int check_count;
    int decodes_compared;
    int empty_reads_wanted;
    int empty_reads_done;
    int cycle_count;
    int checker_errors;
    int monitor_errors;
    int stim_errors;

    assign serial_in = loopback ? serial_out : gen_line;

    uart_top #(
        .CLOCK_FREQ      (CLOCK_FREQ),
        .BAUD_RATE       (BAUD_RATE),
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) i_uart_top (
        .clk        (clk),
        .reset      (reset),
        .tx_data    (tx_data),
        .tx_write   (tx_write),
        .tx_full    (tx_full),
        .rx_read    (rx_read),
        .rx_word    (rx_word),
        .rx_empty   (rx_empty),
        .serial_out (serial_out),
        .serial_in  (serial_in)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // stop bit high means a clean frame
    function automatic rx_word_t expected_word(input byte_t value, input logic stop_bit);
        rx_word_t w;
        w.data        = value;
        w.frame_error = ~stop_bit;
        return w;
    endfunction

    task automatic check_bit(input string name, input logic got, input logic want);
        assert (got == want) else begin
            $display("MISMATCH at %0t: %s expected %b got %b", $time, name, want, got);
            stim_errors++;
        end
    endtask

    task automatic print_counts();
        $display("error counts: checker %0d, monitor %0d, stimulus %0d",
                 checker_errors, monitor_errors, stim_errors);
    endtask

    // one host write, byte expected back clean in loopback
    task automatic write_byte(input byte_t value);
        @(posedge clk);
        tx_data  <= value;
        tx_write <= 1'b1;
        @(posedge clk);
        tx_write <= 1'b0;
        sent.push_back(value);
        expected.push_back(expected_word(value, 1'b1));
    endtask

    // start, data lsb first, stop, 8 cycles per bit
    task automatic send_frame(input byte_t value, input logic stop_bit);
        logic [9:0] frame;
        frame = {stop_bit, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            gen_line <= frame[i];
            repeat (7) @(posedge clk);
        end
        @(posedge clk);
        gen_line <= 1'b1;
    endtask

    // wait until everything sent is decoded and checked, then stay quiet
    task automatic wait_drained();
        while (check_count < expected.size() || decoded.size() < sent.size()) begin
            @(posedge clk);
        end
        repeat (DRAIN_CYCLES) @(posedge clk);
        assert (check_count == expected.size() && decoded.size() == sent.size()) else begin
            $display("at %0t the line or receive fifo gave more than was sent", $time);
            stim_errors++;
        end
        check_bit("rx_empty", rx_empty, 1'b1);
        while (decodes_compared < decoded.size() && decodes_compared < sent.size()) begin
            assert (decoded[decodes_compared] == sent[decodes_compared]) else begin
                $display("MISMATCH at %0t: serial_out byte expected %h got %h", $time,
                         sent[decodes_compared], decoded[decodes_compared]);
                stim_errors++;
            end
            decodes_compared++;
        end
    endtask

    // stimulus
    initial begin
        byte_t value;
        void'($urandom(32'h5ceb));
        reset              = 1'b1;
        tx_data            = '0;
        tx_write           = 1'b0;
        loopback           = 1'b1;
        gen_line           = 1'b1;
        decodes_compared   = 0;
        empty_reads_wanted = 0;
        stim_errors        = 0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // quiet after reset
        repeat (20) begin
            @(posedge clk);
            check_bit("serial_out", serial_out, 1'b1);
            check_bit("rx_empty", rx_empty, 1'b1);
            check_bit("tx_full", tx_full, 1'b0);
        end

        // single byte in loopback
        write_byte(byte_t'($urandom()));
        wait_drained();

        // lead byte keeps the transmitter busy while the burst fills the fifo
        write_byte(8'ha5);
        while (serial_out) @(posedge clk);
        check_bit("tx_full", tx_full, 1'b0);
        for (int i = 0; i < 8; i++) begin
            value = byte_t'($urandom());
            @(posedge clk);
            tx_data  <= value;
            tx_write <= 1'b1;
            sent.push_back(value);
            expected.push_back(expected_word(value, 1'b1));
        end
        @(posedge clk);
        tx_write <= 1'b0;
        @(posedge clk);
        check_bit("tx_full", tx_full, 1'b1);
        // ninth write into a full fifo, must vanish
        tx_data  <= byte_t'($urandom());
        tx_write <= 1'b1;
        @(posedge clk);
        tx_write <= 1'b0;
        @(posedge clk);
        check_bit("tx_full", tx_full, 1'b1);
        wait_drained();

        // injected frames, bad stop bit then a clean one
        @(posedge clk);
        loopback <= 1'b0;
        value = byte_t'($urandom());
        expected.push_back(expected_word(value, 1'b0));
        send_frame(value, 1'b0);
        repeat (16) @(posedge clk);
        value = byte_t'($urandom());
        expected.push_back(expected_word(value, 1'b1));
        send_frame(value, 1'b1);
        wait_drained();
        @(posedge clk);
        loopback <= 1'b1;

        // read strobe on an empty receive fifo
        empty_reads_wanted = 1;
        while (empty_reads_done < empty_reads_wanted) @(posedge clk);
        repeat (2) begin
            @(posedge clk);
            check_bit("rx_empty", rx_empty, 1'b1);
        end
        write_byte(byte_t'($urandom()));
        write_byte(byte_t'($urandom()));
        wait_drained();

        print_counts();
        if (checker_errors == 0 && monitor_errors == 0 && stim_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // line monitor, mid-bit samples after each falling edge
    initial begin
        logic  prev;
        byte_t value;
        prev           = 1'b1;
        monitor_errors = 0;
        forever begin
            @(posedge clk);
            if (!reset && prev && !serial_out) begin
                repeat (3) @(posedge clk);
                assert (serial_out == 1'b0) else begin
                    $display("start bit on serial_out ended before mid-bit at %0t", $time);
                    monitor_errors++;
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (8) @(posedge clk);
                    value[i] = serial_out;
                end
                repeat (8) @(posedge clk);
                assert (serial_out == 1'b1) else begin
                    $display("MISMATCH at %0t: serial_out stop bit expected 1 got 0", $time);
                    monitor_errors++;
                end
                decoded.push_back(value);
            end
            prev = serial_out;
        end
    end

    // checker, pops the receive fifo and compares in order
    initial begin
        rx_read          = 1'b0;
        check_count      = 0;
        empty_reads_done = 0;
        checker_errors   = 0;
        forever begin
            @(posedge clk);
            if (!reset && !rx_empty) begin
                assert (check_count < expected.size()) else begin
                    $display("word %h arrived at %0t with none expected", rx_word, $time);
                    checker_errors++;
                end
                if (check_count < expected.size()) begin
                    assert (rx_word == expected[check_count]) else begin
                        $display("MISMATCH at %0t: rx_word expected %h/%b got %h/%b", $time,
                                 expected[check_count].data, expected[check_count].frame_error,
                                 rx_word.data, rx_word.frame_error);
                        checker_errors++;
                    end
                end
                check_count++;
                rx_read <= 1'b1;
                @(posedge clk);
                rx_read <= 1'b0;
            end else if (!reset && empty_reads_done < empty_reads_wanted) begin
                rx_read <= 1'b1;
                empty_reads_done++;
                @(posedge clk);
                rx_read <= 1'b0;
            end
        end
    end

    // run limit
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the run did not finish", cycle_count);
        print_counts();
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
hdl/uart_pkg.sv
hdl/byte_fifo.sv
hdl/uart_transmitter.sv
hdl/uart_receiver.sv
hdl/uart_top.sv
bench/uart_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the uart testbench with Verilator and run it.
# Exit status is 0 only when the testbench reports a clean run.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=uart_sim

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --assert \
    --top-module uart_tb \
    -f verilog.f \
    --Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

output=$("./$BUILD_DIR/$SIM_BIN")
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "No errors"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
